//--- verilog/rename_settings.svh
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// architectural register file of RV32I
`define RN_ARCH_REGS 32

// physical registers, power of two and above the arch count
`define RN_PHYS_REGS 64

// checkpoint pages for branch recovery
`define RN_PAGES 8

`endif

//--- verilog/rename_pkg.sv
`default_nettype none

`include "rename_settings.svh"

package rename_pkg;

    localparam int ARCH_W = $clog2(`RN_ARCH_REGS);
    localparam int PHYS_W = $clog2(`RN_PHYS_REGS);
    localparam int PAGE_W = $clog2(`RN_PAGES);

    typedef logic [ARCH_W-1:0] arch_reg_t;   // x0..x31
    typedef logic [PHYS_W-1:0] phys_reg_t;   // p0..p63
    typedef logic [PAGE_W-1:0] page_t;       // checkpoint page select

    // what an instruction reads and writes, by major format
    typedef enum logic [2:0] {
        reg_reg,      // r-type
        reg_imm,      // jalr, load, i-type alu
        upper_imm,    // lui, auipc
        jump,         // jal
        branch,
        store,
        illegal       // no sources, no destination
    } op_class_e;

    // rv32i major opcodes, bits 6:0
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_op_imm = 7'b0010011,
        opc_auipc  = 7'b0010111,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_jalr   = 7'b1100111,
        opc_jal    = 7'b1101111
    } opcode_e;

endpackage

`default_nettype wire

//--- verilog/rename_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rename_if;
    import rename_pkg::*;

    logic      valid;
    logic      ready;
    arch_reg_t src1;
    arch_reg_t src2;
    arch_reg_t dst;
    logic      use_src1;    // low for x0 or when not read
    logic      use_src2;
    logic      has_dst;     // low for x0 or no writeback

    modport source (
        output valid, src1, src2, dst, use_src1, use_src2, has_dst,
        input  ready
    );

    modport sink (
        input  valid, src1, src2, dst, use_src1, use_src2, has_dst,
        output ready
    );

endinterface

`default_nettype wire

//--- verilog/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  logic        clock,
    input  logic        reset,
    input  logic        restore,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [31:0] in_instr,
    rename_if.source    dec
);
    import rename_pkg::*;

    logic        full;       // holding register occupied
    logic [31:0] instr_q;
    op_class_e   op_class;
    arch_reg_t   rs1;
    arch_reg_t   rs2;
    arch_reg_t   rd;
    logic        reads_rs1;
    logic        reads_rs2;
    logic        writes_rd;

    // take a new word when empty or when the map drains us this cycle
    assign in_ready = !restore && (!full || dec.ready);

    always_ff @(posedge clock) begin
        if (reset || restore) begin
            full <= 1'b0;                  // flush on mispredict
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            instr_q <= in_instr;
        end
    end

    always_comb begin
        case (instr_q[6:0])
            opc_op:                        op_class = reg_reg;
            opc_op_imm, opc_load, opc_jalr: op_class = reg_imm;
            opc_lui, opc_auipc:            op_class = upper_imm;
            opc_jal:                       op_class = jump;
            opc_branch:                    op_class = branch;
            opc_store:                     op_class = store;
            default:                       op_class = illegal;
        endcase
    end

    assign rs1 = instr_q[19:15];
    assign rs2 = instr_q[24:20];
    assign rd  = instr_q[11:7];      // imm bits for branch and store

    assign reads_rs1 = (op_class inside {reg_reg, reg_imm, branch, store});
    assign reads_rs2 = (op_class inside {reg_reg, branch, store});
    assign writes_rd = (op_class inside {reg_reg, reg_imm, upper_imm, jump});

    assign dec.valid    = full;
    assign dec.src1     = rs1;
    assign dec.src2     = rs2;
    assign dec.dst      = rd;
    assign dec.use_src1 = reads_rs1 && (rs1 != '0);   // x0 is never renamed
    assign dec.use_src2 = reads_rs2 && (rs2 != '0);
    assign dec.has_dst  = writes_rd && (rd != '0);

endmodule

`default_nettype wire

//--- verilog/free_list.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_settings.svh"

module free_list (
    input  logic                  clock,
    input  logic                  reset,
    output logic                  nonempty,
    output rename_pkg::phys_reg_t head_preg,
    input  logic                  alloc,
    input  logic                  release_valid,
    input  rename_pkg::phys_reg_t release_preg,
    input  logic                  save,
    input  rename_pkg::page_t     save_page,
    input  logic                  restore,
    input  rename_pkg::page_t     restore_page
);
    import rename_pkg::*;

    localparam int DEPTH     = `RN_PHYS_REGS;
    localparam int INIT_FREE = `RN_PHYS_REGS - `RN_ARCH_REGS;

    // extra msb tells full from empty
    typedef logic [PHYS_W:0] ptr_t;

    phys_reg_t fifo_mem [DEPTH];
    ptr_t      rd_ptr;
    ptr_t      wr_ptr;
    ptr_t      rd_next;
    ptr_t      page_rd [`RN_PAGES];    // saved read pointers

    assign nonempty  = (rd_ptr != wr_ptr);
    assign head_preg = fifo_mem[rd_ptr[PHYS_W-1:0]];

    // read pointer after this cycle's pop
    always_comb begin
        rd_next = rd_ptr;
        if (alloc) begin
            rd_next = rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (restore) begin
            rd_ptr <= page_rd[restore_page];   // hands back later allocs
        end else begin
            rd_ptr <= rd_next;
        end
    end

    // write side is never rewound so releases survive a restore
    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= ptr_t'(INIT_FREE);
        end else if (release_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < INIT_FREE; i++) begin
                fifo_mem[i] <= phys_reg_t'(i + `RN_ARCH_REGS);   // 32..63
            end
        end else if (release_valid) begin
            fifo_mem[wr_ptr[PHYS_W-1:0]] <= release_preg;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int p = 0; p < `RN_PAGES; p++) begin
                page_rd[p] <= '0;
            end
        end else if (save) begin
            page_rd[save_page] <= rd_next;      // state after this cycle's pop
        end
    end

endmodule

`default_nettype wire

//--- verilog/rename_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_settings.svh"

module rename_map (
    input  logic                  clock,
    input  logic                  reset,
    rename_if.sink                dec,
    input  logic                  fl_nonempty,
    input  rename_pkg::phys_reg_t fl_head,
    output logic                  fl_alloc,
    input  logic                  save,
    input  rename_pkg::page_t     save_page,
    input  logic                  restore,
    input  rename_pkg::page_t     restore_page,
    output logic                  out_valid,
    input  logic                  out_ready,
    output rename_pkg::phys_reg_t out_psrc1,
    output rename_pkg::phys_reg_t out_psrc2,
    output rename_pkg::phys_reg_t out_pdst,
    output rename_pkg::phys_reg_t out_old_pdst,
    output logic                  out_has_dst
);
    import rename_pkg::*;

    localparam int NREGS = `RN_ARCH_REGS;

    phys_reg_t map_q    [NREGS];
    phys_reg_t map_next [NREGS];
    phys_reg_t page_map [`RN_PAGES][NREGS];
    logic      slot_free;     // output register empty or draining
    logic      accept;

    assign slot_free = !out_valid || out_ready;

    // a destination needs a free register, restore blocks everything
    assign dec.ready = !restore && slot_free && (!dec.has_dst || fl_nonempty);
    assign accept    = dec.valid && dec.ready;
    assign fl_alloc  = accept && dec.has_dst;

    // table as it stands after this cycle's rename
    always_comb begin
        map_next = map_q;
        if (fl_alloc) begin
            map_next[dec.dst] = fl_head;
        end
        map_next[0] = '0;             // x0 pinned to p0
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NREGS; i++) begin
                map_q[i] <= phys_reg_t'(i);   // identity
            end
        end else if (restore) begin
            map_q <= page_map[restore_page];
        end else begin
            map_q <= map_next;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int p = 0; p < `RN_PAGES; p++) begin
                for (int i = 0; i < NREGS; i++) begin
                    page_map[p][i] <= phys_reg_t'(i);
                end
            end
        end else if (save) begin
            page_map[save_page] <= map_next;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || restore) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // sources read the table before this rename's update
    always_ff @(posedge clock) begin
        if (accept) begin
            out_psrc1    <= dec.use_src1 ? map_q[dec.src1] : '0;
            out_psrc2    <= dec.use_src2 ? map_q[dec.src2] : '0;
            out_pdst     <= dec.has_dst ? fl_head : '0;
            out_old_pdst <= dec.has_dst ? map_q[dec.dst] : '0;   // freed at retire
            out_has_dst  <= dec.has_dst;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rename_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rename_unit (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [31:0]           in_instr,
    input  logic                  release_valid,
    input  rename_pkg::phys_reg_t release_preg,
    input  logic                  save,
    input  rename_pkg::page_t     save_page,
    input  logic                  restore,
    input  rename_pkg::page_t     restore_page,
    output logic                  out_valid,
    input  logic                  out_ready,
    output rename_pkg::phys_reg_t out_psrc1,
    output rename_pkg::phys_reg_t out_psrc2,
    output rename_pkg::phys_reg_t out_pdst,
    output rename_pkg::phys_reg_t out_old_pdst,
    output logic                  out_has_dst
);

    rename_if dec_if ();

    logic                  fl_nonempty;
    rename_pkg::phys_reg_t fl_head;
    logic                  fl_alloc;

    inst_decoder inst_decoder_i (
        .clock    (clock),
        .reset    (reset),
        .restore  (restore),        // flushes the held word
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_instr (in_instr),
        .dec      (dec_if.source)
    );

    free_list free_list_i (
        .clock         (clock),
        .reset         (reset),
        .nonempty      (fl_nonempty),
        .head_preg     (fl_head),
        .alloc         (fl_alloc),
        .release_valid (release_valid),
        .release_preg  (release_preg),
        .save          (save),
        .save_page     (save_page),
        .restore       (restore),
        .restore_page  (restore_page)
    );

    rename_map rename_map_i (
        .clock        (clock),
        .reset        (reset),
        .dec          (dec_if.sink),
        .fl_nonempty  (fl_nonempty),
        .fl_head      (fl_head),
        .fl_alloc     (fl_alloc),
        .save         (save),
        .save_page    (save_page),
        .restore      (restore),
        .restore_page (restore_page),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_psrc1    (out_psrc1),
        .out_psrc2    (out_psrc2),
        .out_pdst     (out_pdst),
        .out_old_pdst (out_old_pdst),
        .out_has_dst  (out_has_dst)
    );

endmodule

`default_nettype wire

//--- bench/rename_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_settings.svh"

module rename_checker (
    input logic                        clock,
    input logic                        reset,
    input logic                        alloc,
    input logic                        nonempty,
    input logic [rename_pkg::PHYS_W:0] rd_ptr,
    input logic [rename_pkg::PHYS_W:0] wr_ptr,
    input logic                        save,
    input logic                        restore
);
    import rename_pkg::*;

    localparam int MAX_OCC = `RN_PHYS_REGS;

    logic [PHYS_W:0] occupancy;

    assign occupancy = wr_ptr - rd_ptr;    // wraps with the pointers

    no_alloc_when_empty: assert property (@(posedge clock) disable iff (reset)
        alloc |-> nonempty)
        else $error("free list popped while empty");

    occupancy_in_range: assert property (@(posedge clock) disable iff (reset)
        int'(occupancy) <= MAX_OCC)
        else $error("free list holds more entries than physical registers");

    // one checkpoint operation per cycle
    no_save_with_restore: assert property (@(posedge clock) disable iff (reset)
        !(save && restore))
        else $error("save and restore asserted in the same cycle");

endmodule

bind free_list rename_checker checker_i (
    .clock    (clock),
    .reset    (reset),
    .alloc    (alloc),
    .nonempty (nonempty),
    .rd_ptr   (rd_ptr),
    .wr_ptr   (wr_ptr),
    .save     (save),
    .restore  (restore)
);

`default_nettype wire

//--- bench/rename_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_settings.svh"

module rename_tb;
    import rename_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_INSTR    = 130;    // all phases, roughly
    localparam int NREGS        = `RN_ARCH_REGS;
    localparam int NPHYS        = `RN_PHYS_REGS;
    localparam logic [31:0] SEED = 32'hddd8_5139;

    logic        clock = 1'b0;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] in_instr;
    logic        release_valid;
    phys_reg_t   release_preg;
    logic        save;
    page_t       save_page;
    logic        restore;
    page_t       restore_page;
    logic        out_valid;
    logic        out_ready = 1'b1;
    phys_reg_t   out_psrc1;
    phys_reg_t   out_psrc2;
    phys_reg_t   out_pdst;
    phys_reg_t   out_old_pdst;
    logic        out_has_dst;

    phys_reg_t   model_map [NREGS];
    phys_reg_t   saved_map [`RN_PAGES][NREGS];
    int          saved_rd [`RN_PAGES];
    phys_reg_t   fl_mem [NPHYS];
    int          fl_rd;
    int          fl_wr;
    logic [31:0] inst_q [$];       // accepted, not yet out
    phys_reg_t   free_back [$];    // old mappings still to release
    logic [31:0] stim_seed;
    logic [31:0] stall_seed;
    int          ready_mode;       // 0 ready, 1 random stalls, 2 held low
    logic        held;
    logic [25:0] held_fields;
    logic [25:0] out_fields;

    assign out_fields = {out_valid, out_psrc1, out_psrc2, out_pdst, out_old_pdst, out_has_dst};

    rename_unit rename_unit_i (.*);

    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic logic [31:0] lcg(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] make_instr(input logic [6:0] opc, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'd0, rs2, rs1, 3'd0, rd, opc};
    endfunction

    function automatic logic [31:0] random_instr();
        logic [6:0] opc;
        stim_seed = lcg(stim_seed);
        case (stim_seed[31:29])
            3'd0:    opc = opc_op;
            3'd1:    opc = opc_op_imm;
            3'd2:    opc = opc_load;
            3'd3:    opc = opc_jalr;
            3'd4:    opc = opc_lui;
            3'd5:    opc = opc_jal;
            3'd6:    opc = opc_branch;
            default: opc = opc_store;
        endcase
        return make_instr(opc, stim_seed[28:24], stim_seed[23:19], stim_seed[18:14]);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        assert (expected == actual) else abort_run($sformatf(
            "FAIL %0t %s expected %0d actual %0d", $time, name, expected, actual));
    endtask

    // expected rename of one word from the architectural rules
    task automatic check_output(input logic [31:0] w);
        logic [6:0] opc;
        logic       rd1;
        logic       rd2;
        logic       wr;
        phys_reg_t  exp_src1;
        phys_reg_t  exp_src2;
        phys_reg_t  exp_dst;
        phys_reg_t  exp_old;
        opc = w[6:0];
        rd1 = opc inside {opc_op, opc_op_imm, opc_load, opc_jalr, opc_branch, opc_store};
        rd2 = opc inside {opc_op, opc_branch, opc_store};
        wr  = (w[11:7] != 5'd0) &&
              (opc inside {opc_op, opc_op_imm, opc_load, opc_jalr, opc_lui, opc_auipc, opc_jal});
        exp_src1 = rd1 ? model_map[w[19:15]] : '0;    // x0 maps to p0 anyway
        exp_src2 = rd2 ? model_map[w[24:20]] : '0;
        exp_dst  = '0;
        exp_old  = '0;
        if (wr) begin
            exp_old = model_map[w[11:7]];
            exp_dst = fl_mem[fl_rd % NPHYS];
            fl_rd++;
            model_map[w[11:7]] = exp_dst;
            free_back.push_back(exp_old);
        end
        compare("out_psrc1", 32'(exp_src1), 32'(out_psrc1));
        compare("out_psrc2", 32'(exp_src2), 32'(out_psrc2));
        compare("out_pdst", 32'(exp_dst), 32'(out_pdst));
        compare("out_old_pdst", 32'(exp_old), 32'(out_old_pdst));
        compare("out_has_dst", 32'(wr), 32'(out_has_dst));
    endtask

    always @(posedge clock) begin
        if (!reset) begin
            if (held) begin
                compare("held out fields", 32'(held_fields), 32'(out_fields));
            end
            held = out_valid && !out_ready;
            held_fields = out_fields;
            if (out_valid && out_ready) begin
                if (inst_q.size() == 0) begin
                    abort_run("output handshake with no instruction in flight");
                end else begin
                    check_output(inst_q.pop_front());
                end
            end
            if (in_valid && in_ready) begin
                inst_q.push_back(in_instr);
            end
            if (release_valid) begin
                fl_mem[fl_wr % NPHYS] = release_preg;
                fl_wr++;
            end
            if (save) begin
                saved_map[save_page] = model_map;
                saved_rd[save_page] = fl_rd;
            end
            if (restore) begin
                model_map = saved_map[restore_page];
                fl_rd = saved_rd[restore_page];    // later allocs go back
                inst_q.delete();
                free_back.delete();
            end
        end
    end

    always @(posedge clock) begin
        #2;
        stall_seed = lcg(stall_seed);
        case (ready_mode)
            1:       out_ready = (stall_seed[31:30] != 2'd0);    // stall one in four
            2:       out_ready = 1'b0;
            default: out_ready = 1'b1;
        endcase
    end

    task automatic send(input logic [31:0] w);
        in_valid = 1'b1;
        in_instr = w;
        @(posedge clock);
        while (!in_ready) begin
            @(posedge clock);
        end
        #2;
        in_valid = 1'b0;
    endtask

    task automatic drain();
        do begin
            @(posedge clock);
            #2;
        end while (inst_q.size() != 0);
    endtask

    task automatic release_pending();
        while (free_back.size() != 0) begin
            release_valid = 1'b1;
            release_preg  = free_back.pop_front();
            @(posedge clock);
            #2;
        end
        release_valid = 1'b0;
    endtask

    task automatic pulse_save(input page_t p);
        save      = 1'b1;
        save_page = p;
        @(posedge clock);
        #2;
        save = 1'b0;
    endtask

    task automatic pulse_restore(input page_t p);
        restore      = 1'b1;
        restore_page = p;
        @(posedge clock);
        #2;
        restore = 1'b0;
    endtask

    // hold a writing instruction until the stage stops taking it
    task automatic fill_free_list();
        int low_cycles;
        int taken;
        low_cycles = 0;
        taken = 0;
        in_valid = 1'b1;
        in_instr = make_instr(opc_op_imm, 5'd9, 5'd9, 5'd0);
        while (low_cycles < 4) begin
            @(posedge clock);
            if (in_ready) begin
                taken++;
            end
            low_cycles = in_ready ? 0 : low_cycles + 1;
            #2;
        end
        in_valid = 1'b0;
        // every free register handed out, one more word parked in the decoder
        compare("accepted words", 32'(NPHYS - NREGS + 1), 32'(taken));
    endtask

    initial begin
        #((NUM_INSTR * 20 + RESET_CYCLES) * CLK_PERIOD);
        abort_run("timeout: the rename stage stopped making progress");
    end

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        release_valid = 1'b0;
        release_preg = '0;
        save = 1'b0;
        save_page = '0;
        restore = 1'b0;
        restore_page = '0;
        ready_mode = 0;
        held = 1'b0;
        stim_seed = SEED;
        stall_seed = SEED;
        for (int i = 0; i < NREGS; i++) begin
            model_map[i] = phys_reg_t'(i);
            fl_mem[i] = phys_reg_t'(i + NREGS);
        end
        for (int p = 0; p < `RN_PAGES; p++) begin
            saved_map[p] = model_map;
            saved_rd[p] = 0;
        end
        fl_rd = 0;
        fl_wr = NPHYS - NREGS;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        reset = 1'b0;
        compare("in_ready", 32'd1, 32'(in_ready));
        compare("out_valid", 32'd0, 32'(out_valid));

        send(make_instr(opc_op, 5'd5, 5'd1, 5'd2));
        send(make_instr(opc_op_imm, 5'd6, 5'd5, 5'd0));    // reads the fresh p32
        send(make_instr(opc_op, 5'd7, 5'd6, 5'd0));
        send(make_instr(opc_branch, 5'd0, 5'd7, 5'd3));
        send(make_instr(opc_store, 5'd4, 5'd5, 5'd6));
        send(make_instr(7'h7f, 5'd8, 5'd1, 5'd2));         // illegal
        send(make_instr(opc_op_imm, 5'd0, 5'd4, 5'd0));
        send(make_instr(opc_auipc, 5'd8, 5'd0, 5'd0));
        drain();
        release_pending();

        ready_mode = 1;
        repeat (6) begin
            repeat (10) send(random_instr());
            drain();
            release_pending();
        end
        ready_mode = 0;

        pulse_save(3'd3);
        for (int k = 1; k <= 5; k++) begin
            send(make_instr(opc_op, 5'(k), 5'(k), 5'(k + 1)));
        end
        drain();
        pulse_restore(3'd3);
        for (int k = 1; k <= 5; k++) begin
            send(make_instr(opc_op, 5'(k + 10), 5'(k), 5'(k + 1)));
        end
        drain();
        release_pending();

        ready_mode = 2;
        send(random_instr());
        send(random_instr());
        repeat (6) @(posedge clock);
        #2;
        ready_mode = 0;
        drain();
        release_pending();

        fill_free_list();
        release_pending();
        drain();
        repeat (4) send(make_instr(opc_op, 5'd10, 5'd9, 5'd10));
        drain();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verilog
verilog/rename_pkg.sv
verilog/rename_if.sv
verilog/inst_decoder.sv
verilog/free_list.sv
verilog/rename_map.sv
verilog/rename_unit.sv
bench/rename_checker.sv
bench/rename_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
